//--- hdl/lsi_pkg.sv
`default_nettype none

package lsi_pkg;

    // lsi channel field widths
    localparam int SBSP_W = 14;
    localparam int DATA_W = 32;

    // control bus word address, same width as the ethernet core ctrl port
    localparam int WB_ADR_W = 30;

    // register target layout
    localparam int NUM_REGS = 16;
    localparam int REG_IDX_W = $clog2(NUM_REGS);
    localparam int ID_REG_IDX = 15;
    localparam logic [DATA_W-1:0] ID_VALUE = 32'h4C45_7401;

    // rx opcode, anything past write is illegal
    typedef enum logic [2:0] {
        OPC_READ  = 3'b000,
        OPC_WRITE = 3'b001
    } lsi_opc_e;

    // tx error code
    typedef enum logic [1:0] {
        ERR_NONE   = 2'b00,
        ERR_BUS    = 2'b01,
        ERR_OPCODE = 2'b10
    } lsi_err_e;

    // raw lsi request, 49 bits, same order as the rx concatenation
    typedef struct packed {
        logic [SBSP_W-1:0] sbsp;
        logic [DATA_W-1:0] data;
        lsi_opc_e          opc;
    } lsi_req_t;

    // decoded bus command
    typedef struct packed {
        logic [WB_ADR_W-1:0] adr;
        logic [DATA_W-1:0]   wdata;
        logic                we;
        logic                illegal;
    } lsi_cmd_t;

    // bus master side
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [DATA_W-1:0]   dat_w;
    } wb_req_t;

    // bus target side
    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat_r;
    } wb_rsp_t;

    // lsi response word
    typedef struct packed {
        logic [DATA_W-1:0] data;
        lsi_err_e          err_code;
    } lsi_rsp_t;

endpackage

`default_nettype wire

//--- hdl/lsi_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_skid_buffer (
    input  wire logic            host_clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            in_vld_i,
    input  wire lsi_pkg::lsi_req_t in_req_i,
    output logic                 in_busy_o,
    output logic                 out_vld_o,
    output lsi_pkg::lsi_req_t    out_req_o,
    input  wire logic            out_busy_i
);

    logic              main_vld_q;
    logic              skid_vld_q;
    lsi_pkg::lsi_req_t main_req_q;
    lsi_pkg::lsi_req_t skid_req_q;
    logic              in_acc;
    logic              main_free;

    // busy is just the skid flag, so it comes straight from a flop
    assign in_busy_o = skid_vld_q;
    assign in_acc    = in_vld_i && !skid_vld_q;

    // main slot can take a word when empty or being drained this edge
    assign main_free = !main_vld_q || !out_busy_i;

    always_ff @(posedge host_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_vld_q <= 1'b0;
            skid_vld_q <= 1'b0;
        end else if (main_free) begin
            // skid goes first so order holds
            if (skid_vld_q) begin
                main_vld_q <= 1'b1;
                skid_vld_q <= 1'b0;
            end else begin
                main_vld_q <= in_acc;
            end
        end else if (in_acc) begin
            // downstream stalled, park the late arrival
            skid_vld_q <= 1'b1;
        end
    end

    // payload flops
    always_ff @(posedge host_clk_i) begin
        if (main_free) begin
            main_req_q <= skid_vld_q ? skid_req_q : in_req_i;
        end
        if (!main_free && in_acc) begin
            skid_req_q <= in_req_i;
        end
    end

    assign out_vld_o = main_vld_q;
    assign out_req_o = main_req_q;

endmodule

`default_nettype wire

//--- hdl/lsi_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_req_decode (
    input  wire logic              host_clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              req_vld_i,
    input  wire lsi_pkg::lsi_req_t req_i,
    output logic                   req_busy_o,
    output logic                   cmd_vld_o,
    output lsi_pkg::lsi_cmd_t      cmd_o,
    input  wire logic              cmd_busy_i
);

    logic              cmd_vld_q;
    lsi_pkg::lsi_cmd_t cmd_q;
    lsi_pkg::lsi_cmd_t cmd_d;

    // full and stalled, nothing moves
    assign req_busy_o = cmd_vld_q && cmd_busy_i;

    // opcode classification
    always_comb begin
        cmd_d.adr     = lsi_pkg::WB_ADR_W'(req_i.sbsp);
        cmd_d.wdata   = req_i.data;
        cmd_d.we      = (req_i.opc == lsi_pkg::OPC_WRITE);
        // codes 2..7 never reach the bus
        cmd_d.illegal = (req_i.opc != lsi_pkg::OPC_READ) &&
                        (req_i.opc != lsi_pkg::OPC_WRITE);
    end

    always_ff @(posedge host_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd_vld_q <= 1'b0;
        end else if (!req_busy_o) begin
            cmd_vld_q <= req_vld_i;
        end
    end

    always_ff @(posedge host_clk_i) begin
        if (!req_busy_o && req_vld_i) begin
            cmd_q <= cmd_d;
        end
    end

    assign cmd_vld_o = cmd_vld_q;
    assign cmd_o     = cmd_q;

endmodule

`default_nettype wire

//--- hdl/lsi_wb_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_wb_execute (
    input  wire logic              host_clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              cmd_vld_i,
    input  wire lsi_pkg::lsi_cmd_t cmd_i,
    output logic                   cmd_busy_o,
    output lsi_pkg::wb_req_t       wb_req_o,
    input  wire lsi_pkg::wb_rsp_t  wb_rsp_i,
    output logic                   rsp_vld_o,
    output lsi_pkg::lsi_rsp_t      rsp_o,
    input  wire logic              rsp_busy_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_HOLD
    } exe_state_e;

    exe_state_e                     state_q;
    logic                           cmd_take;
    logic                           bus_done;
    logic                           we_q;
    logic [lsi_pkg::WB_ADR_W-1:0]   adr_q;
    logic [lsi_pkg::DATA_W-1:0]     dat_w_q;
    lsi_pkg::lsi_rsp_t              rsp_q;

    // one command in flight, idle is the only state that accepts
    assign cmd_busy_o = (state_q != ST_IDLE);
    assign cmd_take   = cmd_vld_i && (state_q == ST_IDLE);
    assign bus_done   = (state_q == ST_BUS) && (wb_rsp_i.ack || wb_rsp_i.err);

    always_ff @(posedge host_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // illegal opcode skips the bus entirely
                    if (cmd_vld_i) begin
                        state_q <= cmd_i.illegal ? ST_HOLD : ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (bus_done) begin
                        state_q <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (!rsp_busy_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // command and outcome payload
    always_ff @(posedge host_clk_i) begin
        if (cmd_take) begin
            adr_q   <= cmd_i.adr;
            we_q    <= cmd_i.we;
            dat_w_q <= cmd_i.wdata;
        end
        if (cmd_take && cmd_i.illegal) begin
            rsp_q.data     <= '0;
            rsp_q.err_code <= lsi_pkg::ERR_OPCODE;
        end else if (bus_done) begin
            // writes answer with zero data
            rsp_q.data     <= we_q ? '0 : wb_rsp_i.dat_r;
            rsp_q.err_code <= wb_rsp_i.err ? lsi_pkg::ERR_BUS : lsi_pkg::ERR_NONE;
        end
    end

    // stb drops in the ack/err cycle so the target sees exactly one strobe
    assign wb_req_o.cyc   = (state_q == ST_BUS);
    assign wb_req_o.stb   = (state_q == ST_BUS) && !(wb_rsp_i.ack || wb_rsp_i.err);
    assign wb_req_o.we    = we_q;
    assign wb_req_o.adr   = adr_q;
    assign wb_req_o.dat_w = dat_w_q;

    assign rsp_vld_o = (state_q == ST_HOLD);
    assign rsp_o     = rsp_q;

endmodule

`default_nettype wire

//--- hdl/lsi_resp_result.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_resp_result (
    input  wire logic                      host_clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      rsp_vld_i,
    input  wire lsi_pkg::lsi_rsp_t         rsp_i,
    output logic                           rsp_busy_o,
    output logic                           tx_vld_o,
    output logic [lsi_pkg::DATA_W-1:0]     tx_data_o,
    output logic [1:0]                     tx_err_code_o,
    input  wire logic                      tx_busy_i
);

    logic              tx_vld_q;
    lsi_pkg::lsi_rsp_t tx_q;
    logic              load;

    // stalled word blocks the execute stage
    assign rsp_busy_o = tx_vld_q && tx_busy_i;

    // empty, or current word leaves this edge
    assign load = !rsp_busy_o;

    always_ff @(posedge host_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_vld_q <= 1'b0;
        end else if (load) begin
            tx_vld_q <= rsp_vld_i;
        end
    end

    always_ff @(posedge host_clk_i) begin
        if (load && rsp_vld_i) begin
            tx_q <= rsp_i;
        end
    end

    assign tx_vld_o      = tx_vld_q;
    assign tx_data_o     = tx_q.data;
    assign tx_err_code_o = tx_q.err_code;

endmodule

`default_nettype wire

//--- hdl/lsi_reg_target.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_reg_target (
    input  wire logic             host_clk_i,
    input  wire logic             rst_n_i,
    input  wire lsi_pkg::wb_req_t wb_req_i,
    output lsi_pkg::wb_rsp_t      wb_rsp_o
);

    logic [lsi_pkg::DATA_W-1:0]    regs_q [lsi_pkg::NUM_REGS];
    logic [lsi_pkg::REG_IDX_W-1:0] idx;
    logic [lsi_pkg::DATA_W-1:0]    dat_r_q;
    logic                          ack_q;
    logic                          err_q;
    logic                          hit;
    logic                          in_range;
    logic                          id_wr;
    logic                          good;

    // new strobe only, never answer twice for one cycle
    assign hit      = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
    assign idx      = wb_req_i.adr[lsi_pkg::REG_IDX_W-1:0];
    assign in_range = (wb_req_i.adr < lsi_pkg::NUM_REGS);
    // id register is read only
    assign id_wr    = wb_req_i.we && (idx == lsi_pkg::REG_IDX_W'(lsi_pkg::ID_REG_IDX));
    assign good     = in_range && !id_wr;

    // ack or err, one cycle after stb is sampled
    always_ff @(posedge host_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= hit && good;
            err_q <= hit && !good;
        end
    end

    // register file
    always_ff @(posedge host_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < lsi_pkg::NUM_REGS; i++) begin
                regs_q[i] <= (i == lsi_pkg::ID_REG_IDX) ? lsi_pkg::ID_VALUE : '0;
            end
        end else if (hit && good && wb_req_i.we) begin
            regs_q[idx] <= wb_req_i.dat_w;
        end
    end

    // read data, zero outside the map
    always_ff @(posedge host_clk_i) begin
        if (hit) begin
            dat_r_q <= in_range ? regs_q[idx] : '0;
        end
    end

    assign wb_rsp_o.ack   = ack_q;
    assign wb_rsp_o.err   = err_q;
    assign wb_rsp_o.dat_r = dat_r_q;

endmodule

`default_nettype wire

//--- hdl/lsi_eth_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_eth_bridge_top (
    input  wire logic                          host_clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          lsioc_rx_vld_i,
    input  wire logic [lsi_pkg::SBSP_W-1:0]    lsioc_rx_sbsp_i,
    input  wire logic [lsi_pkg::DATA_W-1:0]    lsioc_rx_data_i,
    input  wire logic [2:0]                    lsioc_rx_opc_i,
    output logic                               lsioc_rx_busy_o,
    output logic                               lsioc_tx_vld_o,
    output logic [lsi_pkg::DATA_W-1:0]         lsioc_tx_data_o,
    output logic [1:0]                         lsioc_tx_err_code_o,
    input  wire logic                          lsioc_tx_busy_i
);

    lsi_pkg::lsi_req_t rx_req;
    lsi_pkg::lsi_req_t work_req;
    lsi_pkg::lsi_cmd_t cmd;
    lsi_pkg::lsi_rsp_t rsp;
    lsi_pkg::wb_req_t  wb_req;
    lsi_pkg::wb_rsp_t  wb_rsp;
    logic              work_vld;
    logic              work_busy;
    logic              cmd_vld;
    logic              cmd_busy;
    logic              rsp_vld;
    logic              rsp_busy;

    // rx fields into one request word
    assign rx_req.sbsp = lsioc_rx_sbsp_i;
    assign rx_req.data = lsioc_rx_data_i;
    assign rx_req.opc  = lsi_pkg::lsi_opc_e'(lsioc_rx_opc_i);

    lsi_skid_buffer u_skid (
        .host_clk_i (host_clk_i),
        .rst_n_i    (rst_n_i),
        .in_vld_i   (lsioc_rx_vld_i),
        .in_req_i   (rx_req),
        .in_busy_o  (lsioc_rx_busy_o),
        .out_vld_o  (work_vld),
        .out_req_o  (work_req),
        .out_busy_i (work_busy)
    );

    lsi_req_decode u_decode (
        .host_clk_i (host_clk_i),
        .rst_n_i    (rst_n_i),
        .req_vld_i  (work_vld),
        .req_i      (work_req),
        .req_busy_o (work_busy),
        .cmd_vld_o  (cmd_vld),
        .cmd_o      (cmd),
        .cmd_busy_i (cmd_busy)
    );

    lsi_wb_execute u_execute (
        .host_clk_i (host_clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_vld_i  (cmd_vld),
        .cmd_i      (cmd),
        .cmd_busy_o (cmd_busy),
        .wb_req_o   (wb_req),
        .wb_rsp_i   (wb_rsp),
        .rsp_vld_o  (rsp_vld),
        .rsp_o      (rsp),
        .rsp_busy_i (rsp_busy)
    );

    lsi_resp_result u_result (
        .host_clk_i    (host_clk_i),
        .rst_n_i       (rst_n_i),
        .rsp_vld_i     (rsp_vld),
        .rsp_i         (rsp),
        .rsp_busy_o    (rsp_busy),
        .tx_vld_o      (lsioc_tx_vld_o),
        .tx_data_o     (lsioc_tx_data_o),
        .tx_err_code_o (lsioc_tx_err_code_o),
        .tx_busy_i     (lsioc_tx_busy_i)
    );

    // stands in for the ethernet core ctrl block
    lsi_reg_target u_target (
        .host_clk_i (host_clk_i),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (wb_req),
        .wb_rsp_o   (wb_rsp)
    );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset low for 8 rising edges, released just after the edge
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/lsi_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_bridge_assertions (
    input wire logic                      clk_i,
    input wire logic                      rst_n_i,
    input wire logic                      rx_busy_i,
    input wire logic                      tx_vld_i,
    input wire logic                      tx_busy_i,
    input wire logic [lsi_pkg::DATA_W-1:0] tx_data_i,
    input wire logic [1:0]                tx_err_code_i,
    input wire lsi_pkg::wb_req_t          wb_req_i,
    input wire lsi_pkg::wb_rsp_t          wb_rsp_i
);

    // failure tally, picked up by the testbench top
    int fail_cnt = 0;

    // both lsi outputs quiet while reset is held
    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !tx_vld_i && !rx_busy_i)
        else begin
            fail_cnt++;
            $error("tx_vld or rx_busy high during reset");
        end

    // stalled tx word may not move
    tx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tx_vld_i && tx_busy_i |=> tx_vld_i && $stable(tx_data_i) && $stable(tx_err_code_i))
        else begin
            fail_cnt++;
            $error("tx word changed while stalled");
        end

    // target answers with one of the two, never both
    ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wb_rsp_i.ack && wb_rsp_i.err))
        else begin
            fail_cnt++;
            $error("ack and err high together");
        end

    // every sampled strobe gets exactly one answer next cycle
    stb_answered: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_req_i.cyc && wb_req_i.stb |=> wb_rsp_i.ack ^ wb_rsp_i.err)
        else begin
            fail_cnt++;
            $error("strobe not answered by exactly one of ack or err");
        end

    // and no answer without a strobe before it
    rsp_has_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack || wb_rsp_i.err |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else begin
            fail_cnt++;
            $error("ack or err without a preceding strobe");
        end

endmodule

`default_nettype wire

//--- verification/lsi_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsi_bridge_tb;

    // request counts per phase with the random phase last
    localparam int N_RANDOM    = 60;
    localparam int NUM_REQS    = 30 + 3 + 8 + 12 + N_RANDOM;
    // 40 cycles per request plus the reset cycles
    localparam int WATCHDOG_NS = (NUM_REQS * 40 + 8) * 10;

    logic                       host_clk;
    logic                       rst_n;
    logic                       rx_vld;
    logic [lsi_pkg::SBSP_W-1:0] rx_sbsp;
    logic [lsi_pkg::DATA_W-1:0] rx_data;
    logic [2:0]                 rx_opc;
    logic                       rx_busy;
    logic                       tx_vld;
    logic [lsi_pkg::DATA_W-1:0] tx_data;
    logic [1:0]                 tx_err;
    logic                       tx_busy;
    logic                       busy_mode;
    logic [lsi_pkg::DATA_W-1:0] shadow [lsi_pkg::NUM_REGS];
    logic [lsi_pkg::SBSP_W-1:0] far_adr [4] = '{14'd16, 14'd17, 14'd255, 14'd16383};
    lsi_pkg::lsi_rsp_t          exp_q [$];
    logic [31:0]                r;
    integer                     seed;
    integer                     busy_seed;
    int                         errors;
    int                         n_req;
    int                         n_rsp;
    int                         asrt_fails;

    tb_clk_gen u_clk_gen (
        .clk_o   (host_clk),
        .rst_n_o (rst_n)
    );

    lsi_eth_bridge_top u_lsi_eth_bridge_top (
        .host_clk_i          (host_clk),
        .rst_n_i             (rst_n),
        .lsioc_rx_vld_i      (rx_vld),
        .lsioc_rx_sbsp_i     (rx_sbsp),
        .lsioc_rx_data_i     (rx_data),
        .lsioc_rx_opc_i      (rx_opc),
        .lsioc_rx_busy_o     (rx_busy),
        .lsioc_tx_vld_o      (tx_vld),
        .lsioc_tx_data_o     (tx_data),
        .lsioc_tx_err_code_o (tx_err),
        .lsioc_tx_busy_i     (tx_busy)
    );

    bind lsi_eth_bridge_top lsi_bridge_assertions u_assertions (
        .clk_i         (host_clk_i),
        .rst_n_i       (rst_n_i),
        .rx_busy_i     (lsioc_rx_busy_o),
        .tx_vld_i      (lsioc_tx_vld_o),
        .tx_busy_i     (lsioc_tx_busy_i),
        .tx_data_i     (lsioc_tx_data_o),
        .tx_err_code_i (lsioc_tx_err_code_o),
        .wb_req_i      (wb_req),
        .wb_rsp_i      (wb_rsp)
    );

    // expected response from the target and decode rules with the shadow updated in order
    task automatic apply_model(input logic [13:0] sbsp, input logic [31:0] data,
                               input logic [2:0] opc);
        lsi_pkg::lsi_rsp_t exp;
        exp.data = '0;
        if (opc > 3'd1) begin
            exp.err_code = lsi_pkg::ERR_OPCODE;
        end else if (sbsp >= lsi_pkg::NUM_REGS) begin
            exp.err_code = lsi_pkg::ERR_BUS;
        end else if (opc == 3'd1 && sbsp == lsi_pkg::ID_REG_IDX) begin
            exp.err_code = lsi_pkg::ERR_BUS;
        end else if (opc == 3'd1) begin
            shadow[sbsp] = data;
            exp.err_code = lsi_pkg::ERR_NONE;
        end else begin
            exp.data     = shadow[sbsp];
            exp.err_code = lsi_pkg::ERR_NONE;
        end
        exp_q.push_back(exp);
    endtask

    // hold the request until an edge with busy low; busy only moves at edges
    task automatic send_req(input logic [13:0] sbsp, input logic [31:0] data,
                            input logic [2:0] opc);
        logic taken;
        rx_vld  = 1'b1;
        rx_sbsp = sbsp;
        rx_data = data;
        rx_opc  = opc;
        taken   = 1'b0;
        while (!taken) begin
            taken = !rx_busy;
            @(posedge host_clk);
            #1;
        end
        rx_vld = 1'b0;
        n_req++;
        apply_model(sbsp, data, opc);
    endtask

    task automatic check_rsp();
        lsi_pkg::lsi_rsp_t exp;
        if (exp_q.size() == 0) begin
            errors++;
            $display("a response came out at %0t with no request outstanding", $time);
        end else begin
            exp = exp_q.pop_front();
            n_rsp++;
            assert (tx_data === exp.data && tx_err === exp.err_code) else begin
                errors++;
                $display("[ERROR] %0t response %0d: data %h err %0d, expected data %h err %0d",
                         $time, n_rsp, tx_data, tx_err, exp.data, exp.err_code);
            end
        end
    endtask

    // tx handshake seen half a cycle ahead of its edge while nothing moves
    always @(negedge host_clk) begin
        if (rst_n && tx_vld && !tx_busy) begin
            check_rsp();
        end
    end

    // heavy random back-pressure so the skid entry fills
    always @(posedge host_clk) begin
        #1;
        if (busy_mode) begin
            tx_busy = (($random(busy_seed) & 32'h3) != 0);
        end else begin
            tx_busy = 1'b0;
        end
    end

    initial begin
        rx_vld    = 1'b0;
        rx_sbsp   = '0;
        rx_data   = '0;
        rx_opc    = '0;
        tx_busy   = 1'b0;
        busy_mode = 1'b0;
        errors    = 0;
        n_req     = 0;
        n_rsp     = 0;
        seed      = 55;
        busy_seed = seed + 1;
        for (int i = 0; i < lsi_pkg::NUM_REGS; i++) begin
            shadow[i] = (i == lsi_pkg::ID_REG_IDX) ? lsi_pkg::ID_VALUE : '0;
        end
        @(posedge rst_n);
        @(posedge host_clk);
        #1;
        // writes 0..14 then read back
        for (int i = 0; i < 15; i++) begin
            send_req(14'(i), $random(seed), 3'd1);
        end
        for (int i = 0; i < 15; i++) begin
            send_req(14'(i), 32'h0, 3'd0);
        end
        // id register write must bounce
        send_req(14'(lsi_pkg::ID_REG_IDX), 32'h0, 3'd0);
        send_req(14'(lsi_pkg::ID_REG_IDX), 32'hFFFF_FFFF, 3'd1);
        send_req(14'(lsi_pkg::ID_REG_IDX), 32'h0, 3'd0);
        // outside the map
        foreach (far_adr[i]) begin
            send_req(far_adr[i], 32'h0, 3'd0);
            send_req(far_adr[i], $random(seed), 3'd1);
        end
        // opcodes 2..7 then confirm nothing was written
        for (int i = 0; i < 6; i++) begin
            send_req(14'(i), 32'hBAD0_0000 | i, 3'(i + 2));
        end
        for (int i = 0; i < 6; i++) begin
            send_req(14'(i), 32'h0, 3'd0);
        end
        // back to back under random tx busy
        busy_mode = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            send_req(14'(r[7:0] % 20), $random(seed),
                     (r[9:8] != 2'b00) ? {2'b00, r[10]} : r[12:10]);
        end
        while (exp_q.size() != 0) begin
            @(posedge host_clk);
        end
        busy_mode = 1'b0;
        repeat (4) @(posedge host_clk);
        asrt_fails = u_lsi_eth_bridge_top.u_assertions.fail_cnt;
        $display("errors %0d, assertion failures %0d, responses %0d of %0d requests",
                 errors, asrt_fails, n_rsp, n_req);
        if (errors == 0 && asrt_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("the run timed out with %0d responses still outstanding", exp_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/lsi_pkg.sv
hdl/lsi_skid_buffer.sv
hdl/lsi_req_decode.sv
hdl/lsi_wb_execute.sv
hdl/lsi_resp_result.sv
hdl/lsi_reg_target.sv
hdl/lsi_eth_bridge_top.sv
verification/tb_clk_gen.sv
verification/lsi_bridge_assertions.sv
verification/lsi_bridge_tb.sv

//--- Bender.yml
package:
  name: lsi_eth_bridge

sources:
  - files:
      - hdl/lsi_pkg.sv
      - hdl/lsi_skid_buffer.sv
      - hdl/lsi_req_decode.sv
      - hdl/lsi_wb_execute.sv
      - hdl/lsi_resp_result.sv
      - hdl/lsi_reg_target.sv
      - hdl/lsi_eth_bridge_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/lsi_bridge_assertions.sv
      - verification/lsi_bridge_tb.sv
